/* Makefile */
# Verilator flow for the NoC shell testbench
TOP = tb_noc_shell

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation gave no result"; exit 1; }

clean:
	rm -rf obj_dir sim.log

/* cmd_pkt_parser.sv */
// Command packet parser
// Takes two-word command packets and turns each payload into one
// settings bus write. Sequence number and SIDs stay held for the
// response, and the next command waits until that response is out.

`include "noc_shell_cfg.svh"

module cmd_pkt_parser (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [`DATA_W-1:0]   i_tdata,
   input  logic                 i_tlast,
   input  logic                 i_tvalid,
   output logic                 o_tready,
   output logic                 o_set_stb,
   output logic [`SR_AW-1:0]    o_set_addr,
   output logic [`SR_DW-1:0]    o_set_data,
   output logic [`SEQ_W-1:0]    o_seqnum,
   output logic [2*`SID_W-1:0]  o_sids,
   input  logic                 i_resp_busy
);
   import noc_shell_pkg::*;

   cmd_state_e state;
   logic       busy_seen;
   logic       hdr_ok;

   // A stray non-command or single-word header is consumed and dropped
   assign hdr_ok   = (pkt_type_e'(i_tdata[63:62]) == PKT_CMD) && !i_tlast;
   assign o_tready = (state == CMD_HDR) || (state == CMD_PAYLOAD);

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= CMD_HDR;
         busy_seen <= 1'b0;
         o_set_stb <= 1'b0;
         o_seqnum  <= '0;
         o_sids    <= '0;
      end else begin
         o_set_stb <= 1'b0;
         case (state)
            CMD_HDR: begin
               if (i_tvalid && hdr_ok) begin
                  o_seqnum <= i_tdata[59:48];
                  o_sids   <= i_tdata[31:0];
                  state    <= CMD_PAYLOAD;
               end
            end
            CMD_PAYLOAD: begin
               if (i_tvalid) begin
                  o_set_stb <= 1'b1;
                  state     <= CMD_WAIT_RESP;
               end
            end
            CMD_WAIT_RESP: begin
               // Response is gone once busy has risen and dropped again
               if (i_resp_busy) begin
                  busy_seen <= 1'b1;
               end else if (busy_seen) begin
                  busy_seen <= 1'b0;
                  state     <= CMD_HDR;
               end
            end
            default: state <= CMD_HDR;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == CMD_PAYLOAD && i_tvalid) begin
         o_set_addr <= i_tdata[39:32];
         o_set_data <= i_tdata[31:0];
      end
   end

endmodule

/* noc_shell_cfg.svh */
// NoC shell configuration
// Setting and readback addresses, block identity and bus widths
// for the single-port shell

`ifndef NOC_SHELL_CFG_SVH
`define NOC_SHELL_CFG_SVH

// Bus widths
`define DATA_W 64
`define SID_W 16
`define SEQ_W 12
`define SR_AW 8
`define SR_DW 32

// Shell setting addresses
`define SR_SRC_SID 8'd5
`define SR_NEXT_DST_SID 8'd6
`define SR_RESP_IN_DST_SID 8'd7
`define SR_RESP_OUT_DST_SID 8'd8
`define SR_RB_ADDR_USER 8'd124
`define SR_CLEAR_TX_FC 8'd126
`define SR_RB_ADDR 8'd127

// Block identity
`define NOC_ID 64'hDEAD_BEEF_0123_4567
`define NUM_INPUT_PORTS 1
`define NUM_OUTPUT_PORTS 1
`define GLOBAL_PARAMS_RB {48'd0, 3'd0, 5'(`NUM_INPUT_PORTS), 3'd0, 5'(`NUM_OUTPUT_PORTS)}
`define STR_SINK_FIFOSIZE 11
`define MTU_LOG2 10

// Returned for an unknown readback select
`define BAD_RB_DATA 64'h0BADC0DE0BADC0DE

`endif

/* noc_shell_pkg.sv */
// NoC shell types
// Packet types, command parser states and readback selects

package noc_shell_pkg;

   // Top two bits of every header word
   typedef enum logic [1:0] {
      PKT_DATA = 2'd0,
      PKT_FC   = 2'd1,
      PKT_CMD  = 2'd2,
      PKT_RESP = 2'd3
   } pkt_type_e;

   typedef enum logic [1:0] {
      CMD_HDR,
      CMD_PAYLOAD,
      CMD_WAIT_RESP
   } cmd_state_e;

   // Written through SR_RB_ADDR
   typedef enum logic [2:0] {
      RB_NOC_ID          = 3'd0,
      RB_GLOBAL_PARAMS   = 3'd1,
      RB_FIFOSIZE        = 3'd2,
      RB_MTU             = 3'd3,
      RB_BLOCK_PORT_SIDS = 3'd4,
      RB_USER_RB_DATA    = 3'd5
   } rb_sel_e;

endpackage

/* noc_shell_top.sv */
// NoC shell top level
// Single block port: input type demux, command parser, shell setting
// registers, response builder and output packet mux

`include "noc_shell_cfg.svh"

module noc_shell_top (
   input  logic               clk,
   input  logic               reset,
   // Network side
   input  logic [`DATA_W-1:0] i_tdata,
   input  logic               i_tlast,
   input  logic               i_tvalid,
   output logic               o_tready,
   output logic [`DATA_W-1:0] o_tdata,
   output logic               o_tlast,
   output logic               o_tvalid,
   input  logic               i_tready,
   // Stream sink and source
   output logic [`DATA_W-1:0] o_str_sink_tdata,
   output logic               o_str_sink_tlast,
   output logic               o_str_sink_tvalid,
   input  logic               i_str_sink_tready,
   input  logic [`DATA_W-1:0] i_str_src_tdata,
   input  logic               i_str_src_tlast,
   input  logic               i_str_src_tvalid,
   output logic               o_str_src_tready,
   // User settings bus and readback
   output logic               o_set_stb,
   output logic [`SR_AW-1:0]  o_set_addr,
   output logic [`SR_DW-1:0]  o_set_data,
   input  logic               i_rb_stb,
   input  logic [`DATA_W-1:0] i_rb_data,
   output logic [`SR_AW-1:0]  o_rb_addr,
   // Stream IDs and sequence clear
   output logic [`SID_W-1:0]  o_src_sid,
   output logic [`SID_W-1:0]  o_next_dst_sid,
   output logic [`SID_W-1:0]  o_resp_in_dst_sid,
   output logic [`SID_W-1:0]  o_resp_out_dst_sid,
   output logic               o_clear_tx_seqnum
);
   logic [`DATA_W-1:0]  cmd_tdata;
   logic                cmd_tlast;
   logic                cmd_tvalid;
   logic                cmd_tready;
   logic                set_stb;
   logic [`SR_AW-1:0]   set_addr;
   logic [`SR_DW-1:0]   set_data;
   logic [`SEQ_W-1:0]   cmd_seqnum;
   logic [2*`SID_W-1:0] cmd_sids;
   logic                rb_stb;
   logic [`DATA_W-1:0]  rb_data;
   logic                resp_busy;
   logic [`DATA_W-1:0]  resp_tdata;
   logic                resp_tlast;
   logic                resp_tvalid;
   logic                resp_tready;

   pkt_type_demux pkt_type_demux_inst (
      .clk(clk), .reset(reset),
      .i_tdata(i_tdata), .i_tlast(i_tlast), .i_tvalid(i_tvalid), .o_tready(o_tready),
      .o_sink_tdata(o_str_sink_tdata), .o_sink_tlast(o_str_sink_tlast),
      .o_sink_tvalid(o_str_sink_tvalid), .i_sink_tready(i_str_sink_tready),
      .o_cmd_tdata(cmd_tdata), .o_cmd_tlast(cmd_tlast),
      .o_cmd_tvalid(cmd_tvalid), .i_cmd_tready(cmd_tready)
   );

   cmd_pkt_parser cmd_pkt_parser_inst (
      .clk(clk), .reset(reset),
      .i_tdata(cmd_tdata), .i_tlast(cmd_tlast), .i_tvalid(cmd_tvalid), .o_tready(cmd_tready),
      .o_set_stb(set_stb), .o_set_addr(set_addr), .o_set_data(set_data),
      .o_seqnum(cmd_seqnum), .o_sids(cmd_sids), .i_resp_busy(resp_busy)
   );

   shell_setting_regs shell_setting_regs_inst (
      .clk(clk), .reset(reset),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .o_set_stb(o_set_stb), .o_set_addr(o_set_addr), .o_set_data(o_set_data),
      .i_rb_stb(i_rb_stb), .i_rb_data(i_rb_data), .o_rb_addr(o_rb_addr),
      .o_src_sid(o_src_sid), .o_next_dst_sid(o_next_dst_sid),
      .o_resp_in_dst_sid(o_resp_in_dst_sid), .o_resp_out_dst_sid(o_resp_out_dst_sid),
      .o_clear_tx_seqnum(o_clear_tx_seqnum),
      .o_rbk_stb(rb_stb), .o_rbk_data(rb_data)
   );

   resp_pkt_builder resp_pkt_builder_inst (
      .clk(clk), .reset(reset),
      .i_rbk_stb(rb_stb), .i_rbk_data(rb_data),
      .i_seqnum(cmd_seqnum), .i_sids(cmd_sids), .o_busy(resp_busy),
      .o_tdata(resp_tdata), .o_tlast(resp_tlast), .o_tvalid(resp_tvalid),
      .i_tready(resp_tready)
   );

   out_pkt_mux out_pkt_mux_inst (
      .clk(clk), .reset(reset),
      .i_src_tdata(i_str_src_tdata), .i_src_tlast(i_str_src_tlast),
      .i_src_tvalid(i_str_src_tvalid), .o_src_tready(o_str_src_tready),
      .i_resp_tdata(resp_tdata), .i_resp_tlast(resp_tlast),
      .i_resp_tvalid(resp_tvalid), .o_resp_tready(resp_tready),
      .o_tdata(o_tdata), .o_tlast(o_tlast), .o_tvalid(o_tvalid), .i_tready(i_tready)
   );

endmodule

/* out_pkt_mux.sv */
// Output packet mux
// Merges stream source packets and response packets onto one output.
// A grant lasts for a whole packet, and when both sides wait the
// grant alternates.

`include "noc_shell_cfg.svh"

module out_pkt_mux (
   input  logic               clk,
   input  logic               reset,
   input  logic [`DATA_W-1:0] i_src_tdata,
   input  logic               i_src_tlast,
   input  logic               i_src_tvalid,
   output logic               o_src_tready,
   input  logic [`DATA_W-1:0] i_resp_tdata,
   input  logic               i_resp_tlast,
   input  logic               i_resp_tvalid,
   output logic               o_resp_tready,
   output logic [`DATA_W-1:0] o_tdata,
   output logic               o_tlast,
   output logic               o_tvalid,
   input  logic               i_tready
);
   // sel_q high grants the response side, and it also records the
   // last winner for alternation
   logic active;
   logic sel_q;
   logic pick;

   // Both waiting: the side that lost last time goes next
   assign pick = (i_src_tvalid && i_resp_tvalid) ? !sel_q : i_resp_tvalid;

   assign o_tdata  = sel_q ? i_resp_tdata : i_src_tdata;
   assign o_tlast  = sel_q ? i_resp_tlast : i_src_tlast;
   assign o_tvalid = active && (sel_q ? i_resp_tvalid : i_src_tvalid);

   assign o_src_tready  = active && !sel_q && i_tready;
   assign o_resp_tready = active && sel_q && i_tready;

   always_ff @(posedge clk) begin
      if (reset) begin
         active <= 1'b0;
         sel_q  <= 1'b0;
      end else if (!active) begin
         if (i_src_tvalid || i_resp_tvalid) begin
            active <= 1'b1;
            sel_q  <= pick;
         end
      end else if (o_tvalid && i_tready && o_tlast) begin
         // Release after the last word of the packet
         active <= 1'b0;
      end
   end

endmodule

/* pkt_type_demux.sv */
// Packet type demux
// Steers each input packet by its header type: data to the stream
// sink, commands to the parser, flow control and responses dropped.
// The route is held from the header word until tlast.

`include "noc_shell_cfg.svh"

module pkt_type_demux (
   input  logic              clk,
   input  logic              reset,
   input  logic [`DATA_W-1:0] i_tdata,
   input  logic              i_tlast,
   input  logic              i_tvalid,
   output logic              o_tready,
   output logic [`DATA_W-1:0] o_sink_tdata,
   output logic              o_sink_tlast,
   output logic              o_sink_tvalid,
   input  logic              i_sink_tready,
   output logic [`DATA_W-1:0] o_cmd_tdata,
   output logic              o_cmd_tlast,
   output logic              o_cmd_tvalid,
   input  logic              i_cmd_tready
);
   import noc_shell_pkg::*;

   pkt_type_e route_q;
   pkt_type_e route;
   logic      in_pkt;

   // Header word decides, later words follow the latched route
   assign route = in_pkt ? route_q : pkt_type_e'(i_tdata[63:62]);

   always_comb begin
      case (route)
         PKT_DATA: o_tready = i_sink_tready;
         PKT_CMD:  o_tready = i_cmd_tready;
         // FC and responses are sunk here
         default:  o_tready = 1'b1;
      endcase
   end

   assign o_sink_tdata  = i_tdata;
   assign o_sink_tlast  = i_tlast;
   assign o_sink_tvalid = i_tvalid && (route == PKT_DATA);

   assign o_cmd_tdata  = i_tdata;
   assign o_cmd_tlast  = i_tlast;
   assign o_cmd_tvalid = i_tvalid && (route == PKT_CMD);

   always_ff @(posedge clk) begin
      if (reset) begin
         in_pkt  <= 1'b0;
         route_q <= PKT_DATA;
      end else if (i_tvalid && o_tready) begin
         in_pkt <= !i_tlast;
         if (!in_pkt) begin
            route_q <= route;
         end
      end
   end

endmodule

/* resp_pkt_builder.sv */
// Response packet builder
// Latches the readback word and sends a two-word response: header
// with the command's sequence number and swapped SIDs, then the data

`include "noc_shell_cfg.svh"

module resp_pkt_builder (
   input  logic                clk,
   input  logic                reset,
   input  logic                i_rbk_stb,
   input  logic [`DATA_W-1:0]  i_rbk_data,
   input  logic [`SEQ_W-1:0]   i_seqnum,
   input  logic [2*`SID_W-1:0] i_sids,
   output logic                o_busy,
   output logic [`DATA_W-1:0]  o_tdata,
   output logic                o_tlast,
   output logic                o_tvalid,
   input  logic                i_tready
);
   import noc_shell_pkg::*;

   logic [`DATA_W-1:0] rbk_q;
   logic [`DATA_W-1:0] hdr;
   logic               payload_phase;

   // Source and destination swap, the reply goes back to the sender
   assign hdr = {PKT_RESP, 2'b00, i_seqnum, 16'd0,
                 i_sids[`SID_W-1:0], i_sids[2*`SID_W-1:`SID_W]};

   assign o_tvalid = o_busy;
   assign o_tlast  = payload_phase;
   assign o_tdata  = payload_phase ? rbk_q : hdr;

   always_ff @(posedge clk) begin
      if (reset) begin
         o_busy        <= 1'b0;
         payload_phase <= 1'b0;
      end else if (!o_busy) begin
         o_busy        <= i_rbk_stb;
         payload_phase <= 1'b0;
      end else if (i_tready) begin
         payload_phase <= !payload_phase;
         o_busy        <= !payload_phase;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rbk_stb && !o_busy) begin
         rbk_q <= i_rbk_data;
      end
   end

endmodule

/* shell_setting_regs.sv */
// Shell setting registers
// Decodes settings writes into the SID registers, readback selects
// and the sequence clear pulse, forwards every write to the user,
// and registers one readback word per write.

`include "noc_shell_cfg.svh"

module shell_setting_regs (
   input  logic                clk,
   input  logic                reset,
   input  logic                i_set_stb,
   input  logic [`SR_AW-1:0]   i_set_addr,
   input  logic [`SR_DW-1:0]   i_set_data,
   output logic                o_set_stb,
   output logic [`SR_AW-1:0]   o_set_addr,
   output logic [`SR_DW-1:0]   o_set_data,
   input  logic                i_rb_stb,
   input  logic [`DATA_W-1:0]  i_rb_data,
   output logic [`SR_AW-1:0]   o_rb_addr,
   output logic [`SID_W-1:0]   o_src_sid,
   output logic [`SID_W-1:0]   o_next_dst_sid,
   output logic [`SID_W-1:0]   o_resp_in_dst_sid,
   output logic [`SID_W-1:0]   o_resp_out_dst_sid,
   output logic                o_clear_tx_seqnum,
   output logic                o_rbk_stb,
   output logic [`DATA_W-1:0]  o_rbk_data
);
   import noc_shell_pkg::*;

   logic [`SID_W-1:0]  src_sid_d;
   logic [`SID_W-1:0]  next_dst_sid_d;
   logic [`SID_W-1:0]  resp_in_dst_sid_d;
   logic [`SID_W-1:0]  resp_out_dst_sid_d;
   rb_sel_e            rb_sel;
   rb_sel_e            rb_sel_d;
   logic               rb_pend;
   logic               rb_req;
   logic               rb_ready;
   logic [`DATA_W-1:0] rb_mux;

   // Every write also goes to the user, flow-control addresses included
   assign o_set_stb  = i_set_stb;
   assign o_set_addr = i_set_addr;
   assign o_set_data = i_set_data;

   ////////////////////
   // Register decode
   ////////////////////
   // Next values, so the readback on the following cycle sees the write
   always_comb begin
      src_sid_d          = o_src_sid;
      next_dst_sid_d     = o_next_dst_sid;
      resp_in_dst_sid_d  = o_resp_in_dst_sid;
      resp_out_dst_sid_d = o_resp_out_dst_sid;
      rb_sel_d           = rb_sel;
      if (i_set_stb) begin
         case (i_set_addr)
            `SR_SRC_SID:          src_sid_d          = i_set_data[`SID_W-1:0];
            `SR_NEXT_DST_SID:     next_dst_sid_d     = i_set_data[`SID_W-1:0];
            `SR_RESP_IN_DST_SID:  resp_in_dst_sid_d  = i_set_data[`SID_W-1:0];
            `SR_RESP_OUT_DST_SID: resp_out_dst_sid_d = i_set_data[`SID_W-1:0];
            `SR_RB_ADDR:          rb_sel_d           = rb_sel_e'(i_set_data[2:0]);
            default: ;
         endcase
      end
   end

   ////////////////////
   // Readback
   ////////////////////
   assign rb_req   = i_set_stb || rb_pend;
   // User readback holds until the user strobes
   assign rb_ready = (rb_sel_d != RB_USER_RB_DATA) || i_rb_stb;

   always_comb begin
      case (rb_sel_d)
         RB_NOC_ID:          rb_mux = `NOC_ID;
         RB_GLOBAL_PARAMS:   rb_mux = `GLOBAL_PARAMS_RB;
         RB_FIFOSIZE:        rb_mux = 64'(`STR_SINK_FIFOSIZE);
         RB_MTU:             rb_mux = 64'(`MTU_LOG2);
         RB_BLOCK_PORT_SIDS: rb_mux = {src_sid_d, next_dst_sid_d,
                                       resp_in_dst_sid_d, resp_out_dst_sid_d};
         RB_USER_RB_DATA:    rb_mux = i_rb_data;
         default:            rb_mux = `BAD_RB_DATA;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         o_src_sid          <= '0;
         o_next_dst_sid     <= '0;
         o_resp_in_dst_sid  <= '0;
         o_resp_out_dst_sid <= '0;
         rb_sel             <= RB_NOC_ID;
         o_rb_addr          <= '0;
         o_clear_tx_seqnum  <= 1'b0;
         o_rbk_stb          <= 1'b0;
         rb_pend            <= 1'b0;
      end else begin
         o_src_sid          <= src_sid_d;
         o_next_dst_sid     <= next_dst_sid_d;
         o_resp_in_dst_sid  <= resp_in_dst_sid_d;
         o_resp_out_dst_sid <= resp_out_dst_sid_d;
         rb_sel             <= rb_sel_d;
         if (i_set_stb && i_set_addr == `SR_RB_ADDR_USER) begin
            o_rb_addr <= i_set_data[`SR_AW-1:0];
         end
         o_clear_tx_seqnum <= i_set_stb && (i_set_addr == `SR_CLEAR_TX_FC);
         o_rbk_stb         <= rb_req && rb_ready;
         rb_pend           <= rb_req && !rb_ready;
      end
   end

   always_ff @(posedge clk) begin
      if (rb_req && rb_ready) begin
         o_rbk_data <= rb_mux;
      end
   end

endmodule

/* sim.f */
+incdir+.
noc_shell_pkg.sv
pkt_type_demux.sv
cmd_pkt_parser.sv
shell_setting_regs.sv
resp_pkt_builder.sv
out_pkt_mux.sv
noc_shell_top.sv
tb_noc_shell.sv

/* tb_noc_shell_ref.svh */
// NoC shell reference model
// Expected readback word for a select and a register state, and the
// expected response header for a command

`ifndef TB_NOC_SHELL_REF_SVH
`define TB_NOC_SHELL_REF_SVH

// Readback after a write, taken from the modelled register state
function automatic logic [63:0] expected_readback(
   input logic [2:0]  sel,
   input logic [15:0] src_sid,
   input logic [15:0] next_dst_sid,
   input logic [15:0] resp_in_dst_sid,
   input logic [15:0] resp_out_dst_sid,
   input logic [63:0] user_data
);
   case (sel)
      RB_NOC_ID:          return `NOC_ID;
      // Port counts sit in 5-bit fields at 12:8 and 4:0
      RB_GLOBAL_PARAMS:   return (64'(`NUM_INPUT_PORTS) << 8) | 64'(`NUM_OUTPUT_PORTS);
      RB_FIFOSIZE:        return 64'(`STR_SINK_FIFOSIZE);
      RB_MTU:             return 64'(`MTU_LOG2);
      RB_BLOCK_PORT_SIDS: return {src_sid, next_dst_sid, resp_in_dst_sid, resp_out_dst_sid};
      RB_USER_RB_DATA:    return user_data;
      default:            return `BAD_RB_DATA;
   endcase
endfunction

// Reply header keeps the sequence number, source and destination swap
function automatic logic [63:0] expected_resp_header(
   input logic [11:0] seqnum,
   input logic [15:0] cmd_src_sid,
   input logic [15:0] cmd_dst_sid
);
   return {PKT_RESP, 2'b00, seqnum, 16'd0, cmd_dst_sid, cmd_src_sid};
endfunction

`endif

/* tb_noc_shell.sv */
// NoC shell testbench
// Sends commands, data packets and discarded packets into the shell,
// drives the stream source with random stalls, and checks the settings
// bus, the stream sink and the output stream against a register model

`include "noc_shell_cfg.svh"

module tb_noc_shell;
   import noc_shell_pkg::*;

`include "tb_noc_shell_ref.svh"

   localparam logic [63:0] USER_RB_WORD = 64'hFEED_5A5A_C3C3_0F0F;
   localparam int          N_RAND_CMDS  = 24;
   localparam int          N_SRC_PKTS   = 30;

   logic               clk = 1'b0;
   logic               reset = 1'b1;
   logic [`DATA_W-1:0] i_tdata = '0;
   logic               i_tlast = 1'b0;
   logic               i_tvalid = 1'b0;
   logic               i_str_sink_tready = 1'b0;
   logic [`DATA_W-1:0] i_str_src_tdata = '0;
   logic               i_str_src_tlast = 1'b0;
   logic               i_str_src_tvalid = 1'b0;
   logic               i_tready = 1'b0;
   // User readback answers at once with a fixed word
   logic               i_rb_stb = 1'b1;
   logic [`DATA_W-1:0] i_rb_data = USER_RB_WORD;
   logic               o_tready;
   logic [`DATA_W-1:0] o_tdata;
   logic               o_tlast;
   logic               o_tvalid;
   logic [`DATA_W-1:0] o_str_sink_tdata;
   logic               o_str_sink_tlast;
   logic               o_str_sink_tvalid;
   logic               o_str_src_tready;
   logic               o_set_stb;
   logic [`SR_AW-1:0]  o_set_addr;
   logic [`SR_DW-1:0]  o_set_data;
   logic [`SR_AW-1:0]  o_rb_addr;
   logic [`SID_W-1:0]  o_src_sid;
   logic [`SID_W-1:0]  o_next_dst_sid;
   logic [`SID_W-1:0]  o_resp_in_dst_sid;
   logic [`SID_W-1:0]  o_resp_out_dst_sid;
   logic               o_clear_tx_seqnum;

   // Register model updated as each command is sent
   logic [15:0] m_sid[4] = '{default: 16'd0};
   logic [2:0]  m_rb_sel = 3'd0;
   logic [7:0]  m_rb_addr = 8'd0;
   logic [11:0] cmd_seq = 12'hFF0;
   int          clear_expected = 0;
   int          clear_seen = 0;
   int          planned_words = 0;

   logic [7:0]  plan_addr[$];
   logic [31:0] plan_data[$];
   // Expected words as {addr, data} and {last, data}
   logic [39:0] exp_set_q[$];
   logic [63:0] exp_hdr_q[$];
   logic [63:0] exp_rbk_q[$];
   logic [63:0] exp_sids_q[$];
   logic [7:0]  exp_rb_addr_q[$];
   logic [64:0] exp_src_q[$];
   logic [64:0] exp_sink_q[$];

   logic        out_in_pkt = 1'b0;
   logic        out_is_resp = 1'b0;
   int          out_idx = 0;

   noc_shell_top noc_shell_top_inst (.*);

   always #50 clk = ~clk;

   // Random stalls on the sink and the output
   always @(negedge clk) begin
      i_str_sink_tready = ($urandom_range(0, 9) < 7);
      i_tready          = ($urandom_range(0, 9) < 7);
   end

   task automatic report_error(input string msg);
      $display("error: time %0t: %s", $time, msg);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic add_cmd(input logic [7:0] addr, input logic [31:0] data);
      plan_addr.push_back(addr);
      plan_data.push_back(data);
   endtask

   task automatic build_plan();
      int         n;
      logic [7:0] addr;
      // Block ID readback comes first straight after reset
      add_cmd(`SR_RB_ADDR, 32'd0);
      add_cmd(`SR_SRC_SID, $urandom);
      add_cmd(`SR_NEXT_DST_SID, $urandom);
      add_cmd(`SR_RESP_IN_DST_SID, $urandom);
      add_cmd(`SR_RESP_OUT_DST_SID, $urandom);
      for (n = 1; n <= 7; n++) begin
         add_cmd(`SR_RB_ADDR, 32'(n));
      end
      add_cmd(`SR_RB_ADDR_USER, $urandom);
      add_cmd(`SR_CLEAR_TX_FC, $urandom);
      add_cmd(8'd200, $urandom);
      for (n = 0; n < N_RAND_CMDS; n++) begin
         case ($urandom_range(0, 3))
            0:       addr = `SR_RB_ADDR;
            1:       addr = `SR_RB_ADDR_USER;
            2:       addr = 8'(`SR_SRC_SID + $urandom_range(0, 3));
            default: addr = 8'($urandom);
         endcase
         add_cmd(addr, $urandom);
      end
      planned_words = plan_addr.size() * 13 + N_SRC_PKTS * 4;
   endtask

   task automatic apply_write(input logic [7:0] addr, input logic [31:0] data);
      case (addr)
         `SR_SRC_SID:          m_sid[0] = data[15:0];
         `SR_NEXT_DST_SID:     m_sid[1] = data[15:0];
         `SR_RESP_IN_DST_SID:  m_sid[2] = data[15:0];
         `SR_RESP_OUT_DST_SID: m_sid[3] = data[15:0];
         `SR_RB_ADDR_USER:     m_rb_addr = data[7:0];
         `SR_CLEAR_TX_FC:      clear_expected = clear_expected + 1;
         `SR_RB_ADDR:          m_rb_sel = data[2:0];
         default: ;
      endcase
   endtask

   ////////////////////
   // Input stimulus
   ////////////////////
   task automatic send_word(input logic [63:0] data, input logic last);
      @(negedge clk);
      i_tdata  = data;
      i_tlast  = last;
      i_tvalid = 1'b1;
      @(posedge clk);
      while (!o_tready) begin
         @(posedge clk);
      end
   endtask

   task automatic end_packet();
      @(negedge clk);
      i_tvalid = 1'b0;
      repeat ($urandom_range(0, 2)) @(negedge clk);
   endtask

   task automatic send_cmd(input logic [7:0] addr, input logic [31:0] data);
      logic [11:0] seq;
      logic [15:0] src;
      logic [15:0] dst;
      seq     = cmd_seq;
      cmd_seq = cmd_seq + 12'd1;
      src     = 16'($urandom);
      dst     = 16'($urandom);
      apply_write(addr, data);
      exp_set_q.push_back({addr, data});
      exp_hdr_q.push_back(expected_resp_header(seq, src, dst));
      exp_rbk_q.push_back(expected_readback(m_rb_sel, m_sid[0], m_sid[1], m_sid[2],
                                            m_sid[3], USER_RB_WORD));
      exp_sids_q.push_back({m_sid[0], m_sid[1], m_sid[2], m_sid[3]});
      exp_rb_addr_q.push_back(m_rb_addr);
      send_word({PKT_CMD, 2'b00, seq, 16'd0, src, dst}, 1'b0);
      send_word({24'($urandom), addr, data}, 1'b1);
      end_packet();
   endtask

   task automatic send_packet(input pkt_type_e kind, input int len);
      int          i;
      logic [63:0] word;
      for (i = 0; i < len; i++) begin
         word = {$urandom, $urandom};
         if (i == 0) begin
            word[63:62] = kind;
         end
         if (kind == PKT_DATA) begin
            exp_sink_q.push_back({i == len - 1, word});
         end
         send_word(word, i == len - 1);
      end
      end_packet();
   endtask

   task automatic drive_input();
      int i;
      for (i = 0; i < plan_addr.size(); i++) begin
         send_cmd(plan_addr[i], plan_data[i]);
         if ($urandom_range(0, 1) == 1) begin
            send_packet(PKT_DATA, $urandom_range(1, 6));
         end
         // Flow control and responses must vanish in the demux
         if (i % 5 == 2) begin
            send_packet(PKT_FC, $urandom_range(1, 3));
         end
         if (i % 7 == 3) begin
            send_packet(PKT_RESP, $urandom_range(1, 3));
         end
      end
   endtask

   task automatic drive_source();
      int          p;
      int          i;
      int          len;
      logic [63:0] word;
      for (p = 0; p < N_SRC_PKTS; p++) begin
         len = $urandom_range(1, 4);
         for (i = 0; i < len; i++) begin
            word = {$urandom, $urandom};
            if (i == 0) begin
               word[63:62] = PKT_DATA;
            end
            exp_src_q.push_back({i == len - 1, word});
            @(negedge clk);
            i_str_src_tdata  = word;
            i_str_src_tlast  = (i == len - 1);
            i_str_src_tvalid = 1'b1;
            @(posedge clk);
            while (!o_str_src_tready) begin
               @(posedge clk);
            end
         end
         @(negedge clk);
         i_str_src_tvalid = 1'b0;
         repeat ($urandom_range(0, 8)) @(negedge clk);
      end
   endtask

   ////////////////////
   // Output checks
   ////////////////////
   always @(posedge clk) begin
      if (!reset && o_set_stb) begin
         assert (exp_set_q.size() > 0) else report_error("settings write with no command sent");
         assert ({o_set_addr, o_set_data} == exp_set_q[0]) else
            report_error($sformatf("settings write %h:%h, expected %h:%h", o_set_addr,
                                   o_set_data, exp_set_q[0][39:32], exp_set_q[0][31:0]));
         void'(exp_set_q.pop_front());
      end
      if (!reset && o_clear_tx_seqnum) begin
         clear_seen = clear_seen + 1;
      end
   end

   always @(posedge clk) begin
      if (!reset && o_str_sink_tvalid && i_str_sink_tready) begin
         assert (exp_sink_q.size() > 0) else report_error("sink word with no data packet sent");
         assert ({o_str_sink_tlast, o_str_sink_tdata} == exp_sink_q[0]) else
            report_error($sformatf("sink word %h last %b, expected %h last %b",
                                   o_str_sink_tdata, o_str_sink_tlast,
                                   exp_sink_q[0][63:0], exp_sink_q[0][64]));
         void'(exp_sink_q.pop_front());
      end
   end

   // Packet kind is fixed by the first word and held to tlast
   always @(posedge clk) begin
      if (!reset && o_tvalid && i_tready) begin
         if (!out_in_pkt) begin
            out_is_resp = (o_tdata[63:62] == PKT_RESP);
            out_idx     = 0;
         end
         if (!out_is_resp) begin
            assert (exp_src_q.size() > 0) else report_error("source word with none pending");
            assert ({o_tlast, o_tdata} == exp_src_q[0]) else
               report_error($sformatf("source word %h last %b, expected %h last %b",
                                      o_tdata, o_tlast, exp_src_q[0][63:0], exp_src_q[0][64]));
            void'(exp_src_q.pop_front());
         end else if (out_idx == 0) begin
            assert (exp_hdr_q.size() > 0) else report_error("response with no command pending");
            assert (o_tdata == exp_hdr_q[0] && !o_tlast) else
               report_error($sformatf("response header %h last %b, expected %h",
                                      o_tdata, o_tlast, exp_hdr_q[0]));
         end else begin
            assert (o_tdata == exp_rbk_q[0] && o_tlast) else
               report_error($sformatf("readback %h last %b, expected %h",
                                      o_tdata, o_tlast, exp_rbk_q[0]));
            assert ({o_src_sid, o_next_dst_sid, o_resp_in_dst_sid, o_resp_out_dst_sid}
                    == exp_sids_q[0]) else
               report_error($sformatf("SID ports %h %h %h %h, expected %h", o_src_sid,
                                      o_next_dst_sid, o_resp_in_dst_sid,
                                      o_resp_out_dst_sid, exp_sids_q[0]));
            assert (o_rb_addr == exp_rb_addr_q[0]) else
               report_error($sformatf("rb_addr %h, expected %h", o_rb_addr, exp_rb_addr_q[0]));
            void'(exp_hdr_q.pop_front());
            void'(exp_rbk_q.pop_front());
            void'(exp_sids_q.pop_front());
            void'(exp_rb_addr_q.pop_front());
         end
         out_in_pkt = !o_tlast;
         out_idx    = out_idx + 1;
      end
   end

   // Watchdog scaled by the planned traffic
   initial begin
      wait (planned_words > 0);
      repeat (planned_words * 20) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles", planned_words * 20);
      $display("CHECKS FAILED");
      $fatal(1);
   end

   initial begin
      void'($urandom(32'h0462_1106));
      build_plan();
      repeat (4) @(negedge clk);
      reset = 1'b0;
      fork
         drive_input();
         drive_source();
      join
      while (exp_set_q.size() + exp_hdr_q.size() + exp_src_q.size()
             + exp_sink_q.size() > 0) begin
         @(posedge clk);
      end
      // Quiet tail to catch stray words
      repeat (20) @(posedge clk);
      if (clear_seen == clear_expected) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         report_error($sformatf("%0d clear pulses, expected %0d", clear_seen, clear_expected));
      end
   end

endmodule
